//--- rtl/nspace_pkg.sv
// nspace sprite video constants, download map, widths and sprite word views
package nspace_pkg;

    // ========================================
    // widths
    localparam int DL_ADDR_W   = 25;
    localparam int SPR_ADDR_W  = 12;
    localparam int GFX_ADDR_W  = 18;
    localparam int LBUF_ADDR_W = 10;

    // download map, byte offsets in the stream
    localparam logic [DL_ADDR_W-1:0] TILE_COL_BASE = 25'h110000;
    localparam logic [DL_ADDR_W-1:0] TILE_COL_LEN  = 25'h008000;
    localparam logic [DL_ADDR_W-1:0] CLUT_BASE     = 25'h118000;
    localparam logic [DL_ADDR_W-1:0] CLUT_LEN      = 25'h000800;
    localparam logic [DL_ADDR_W-1:0] PAL_BASE      = 25'h118800;
    localparam logic [DL_ADDR_W-1:0] PAL_LEN       = 25'h000400;

    // ========================================
    // renderer
    localparam int LINE_CLEAR_LEN = 257;
    localparam int NUM_COLS       = 32;
    localparam int NUM_LAYERS     = 3;
    // entry 0 is drawn first, so group 1 lands on top
    localparam logic [NUM_LAYERS-1:0][1:0] LAYER_GROUP = {2'd1, 2'd3, 2'd2};
    localparam logic [7:0] COL_Y_ORIGIN = 8'd1;

    // column walk FSM states
    localparam logic [3:0] RS_IDLE      = 4'd0;
    localparam logic [3:0] RS_CLEAR     = 4'd1;
    localparam logic [3:0] RS_LAYER     = 4'd2;
    localparam logic [3:0] RS_POS_RD    = 4'd3;
    localparam logic [3:0] RS_POS_WAIT  = 4'd4;
    localparam logic [3:0] RS_POS_USE   = 4'd5;
    localparam logic [3:0] RS_TILE_RD   = 4'd6;
    localparam logic [3:0] RS_TILE_WAIT = 4'd7;
    localparam logic [3:0] RS_TILE_USE  = 4'd8;
    localparam logic [3:0] RS_COL_WAIT  = 4'd9;
    localparam logic [3:0] RS_COL_USE   = 4'd10;
    localparam logic [3:0] RS_FETCH     = 4'd11;
    localparam logic [3:0] RS_GFX_WAIT  = 4'd12;
    localparam logic [3:0] RS_DRAW      = 4'd13;
    localparam logic [3:0] RS_NEXT      = 4'd14;

    // readout
    localparam int PIX_LATENCY = 4;

    // one sprite RAM word, either a column position or a tile entry
    typedef union packed {
        struct packed {
            logic [7:0] y;
            logic [7:0] x;
        } pos;
        struct packed {
            logic        col_sel;
            logic        flip;
            logic [13:0] tile_num;
        } tile;
    } spr_word_u;

endpackage

//--- rtl/table_loader.sv
// table loader, turns the byte download stream into tile colour, CLUT and palette writes
module table_loader (
    input  logic                             clk_sys,
    input  logic                             reset,
    input  logic                             dl_active,
    input  logic                             dl_wr,
    input  logic [nspace_pkg::DL_ADDR_W-1:0] dl_addr,
    input  logic [7:0]                       dl_data,
    output logic                             tcol_we,
    output logic [14:0]                      tcol_waddr,
    output logic [7:0]                       tcol_wdata,
    output logic                             clut_we,
    output logic [9:0]                       clut_waddr,
    output logic [7:0]                       clut_wdata,
    output logic                             pal_we,
    output logic [7:0]                       pal_waddr,
    output logic [31:0]                      pal_wdata
);
    import nspace_pkg::*;

    logic                 dl_byte;
    logic [DL_ADDR_W-1:0] tcol_off;
    logic [DL_ADDR_W-1:0] clut_off;
    logic [DL_ADDR_W-1:0] pal_off;
    logic                 in_tcol;
    logic                 in_clut;
    logic                 in_pal;
    logic [3:0]           clut_hold;
    logic [23:0]          pal_hold;

    assign dl_byte  = dl_active & dl_wr;
    // addresses below a base wrap to huge offsets and fail the length test
    assign tcol_off = dl_addr - TILE_COL_BASE;
    assign clut_off = dl_addr - CLUT_BASE;
    assign pal_off  = dl_addr - PAL_BASE;
    assign in_tcol  = dl_byte && (tcol_off < TILE_COL_LEN);
    assign in_clut  = dl_byte && (clut_off < CLUT_LEN);
    assign in_pal   = dl_byte && (pal_off < PAL_LEN);

    // strobes fire on the last byte of each entry
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            tcol_we <= 1'b0;
            clut_we <= 1'b0;
            pal_we  <= 1'b0;
        end else begin
            tcol_we <= in_tcol;
            clut_we <= in_clut & clut_off[0];
            pal_we  <= in_pal & (pal_off[1:0] == 2'b11);
        end
    end

    always_ff @(posedge clk_sys) begin
        tcol_waddr <= tcol_off[14:0];
        tcol_wdata <= dl_data;
        // clut, low nibble of each byte only
        if (in_clut) begin
            if (!clut_off[0]) begin
                clut_hold <= dl_data[3:0];
            end
            clut_waddr <= clut_off[10:1];
            clut_wdata <= {dl_data[3:0], clut_hold};
        end
        // palette, msb first
        if (in_pal) begin
            case (pal_off[1:0])
                2'd0:    pal_hold[23:16] <= dl_data;
                2'd1:    pal_hold[15:8]  <= dl_data;
                2'd2:    pal_hold[7:0]   <= dl_data;
                default: pal_wdata       <= {pal_hold, dl_data};
            endcase
            pal_waddr <= pal_off[9:2];
        end
    end

endmodule

//--- rtl/sprite_column_renderer.sv
// sprite column renderer, walks three layers of columns into the line buffer
module sprite_column_renderer (
    input  logic                               clk_sys,
    input  logic                               reset,
    input  logic                               line_start,
    input  logic [8:0]                         line_num,
    input  logic                               spr_wr,
    input  logic [nspace_pkg::SPR_ADDR_W-1:0]  spr_addr,
    input  nspace_pkg::spr_word_u              spr_data,
    input  logic                               tcol_we,
    input  logic [14:0]                        tcol_waddr,
    input  logic [7:0]                         tcol_wdata,
    input  logic                               gfx_valid,
    input  logic [15:0]                        gfx_data,
    output logic                               gfx_req,
    output logic [nspace_pkg::GFX_ADDR_W-1:0]  gfx_addr,
    output logic                               lbuf_we,
    output logic [nspace_pkg::LBUF_ADDR_W-1:0] lbuf_waddr,
    output logic [15:0]                        lbuf_wdata,
    output logic                               render_busy
);
    import nspace_pkg::*;

    spr_word_u             spr_ram [2**SPR_ADDR_W];
    spr_word_u             spr_rdata;
    logic [SPR_ADDR_W-1:0] spr_raddr;
    logic [7:0]            tcol_ram [32768];
    logic [7:0]            tcol_rdata;
    logic [14:0]           tcol_raddr;

    logic [3:0]  state;
    logic [1:0]  layer;
    logic [1:0]  group;
    logic [4:0]  col;
    logic [7:0]  col_x;
    logic [7:0]  col_y;
    logic [7:0]  row_idx;
    logic [13:0] tile_num;
    logic        flip_y;
    logic [7:0]  colour;
    logic        half;
    logic [1:0]  ofs;
    logic [8:0]  xpos;
    logic [15:0] pix_data;
    logic [3:0]  pen;
    logic        parity;

    // ========================================
    // memories

    // host writes, renderer reads
    always_ff @(posedge clk_sys) begin
        if (spr_wr) begin
            spr_ram[spr_addr] <= spr_data;
        end
        spr_rdata <= spr_ram[spr_raddr];
    end

    always_ff @(posedge clk_sys) begin
        if (tcol_we) begin
            tcol_ram[tcol_waddr] <= tcol_wdata;
        end
        tcol_rdata <= tcol_ram[tcol_raddr];
    end

    // ========================================
    // column walk

    assign parity = line_num[0];
    // only meaningful while the position word is on spr_rdata
    assign col_y  = COL_Y_ORIGIN - spr_rdata.pos.y;
    // pen bits 4+o, 0+o, 12+o, 8+o
    assign pen    = {pix_data[{2'b01, ofs}], pix_data[{2'b00, ofs}],
                     pix_data[{2'b11, ofs}], pix_data[{2'b10, ofs}]};

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state       <= RS_IDLE;
            render_busy <= 1'b0;
            gfx_req     <= 1'b0;
            lbuf_we     <= 1'b0;
        end else begin
            lbuf_we <= 1'b0;
            case (state)
                RS_IDLE: begin
                    if (line_start) begin
                        render_busy <= 1'b1;
                        xpos        <= '0;
                        layer       <= '0;
                        state       <= RS_CLEAR;
                    end
                end
                RS_CLEAR: begin
                    // xpos doubles as the clear position
                    lbuf_we    <= 1'b1;
                    lbuf_waddr <= {parity, xpos};
                    lbuf_wdata <= '0;
                    xpos       <= xpos + 9'd1;
                    if (xpos == 9'(LINE_CLEAR_LEN - 1)) begin
                        state <= RS_LAYER;
                    end
                end
                RS_LAYER: begin
                    col   <= '0;
                    group <= LAYER_GROUP[layer];
                    state <= RS_POS_RD;
                end
                RS_POS_RD: begin
                    spr_raddr <= {2'b00, col, 3'b000, group};
                    state     <= RS_POS_WAIT;
                end
                RS_POS_WAIT: state <= RS_POS_USE;
                RS_POS_USE: begin
                    col_x   <= spr_rdata.pos.x;
                    row_idx <= line_num[7:0] - col_y;
                    state   <= RS_TILE_RD;
                end
                RS_TILE_RD: begin
                    // one tile word per 8 rows of the column
                    spr_raddr <= {group, col, row_idx[7:3]};
                    state     <= RS_TILE_WAIT;
                end
                RS_TILE_WAIT: state <= RS_TILE_USE;
                RS_TILE_USE: begin
                    tile_num   <= spr_rdata.tile.tile_num;
                    flip_y     <= spr_rdata.tile.flip;
                    tcol_raddr <= {spr_rdata.tile.tile_num, spr_rdata.tile.col_sel};
                    state      <= RS_COL_WAIT;
                end
                RS_COL_WAIT: state <= RS_COL_USE;
                RS_COL_USE: begin
                    colour <= tcol_rdata;
                    half   <= 1'b0;
                    ofs    <= '0;
                    xpos   <= {1'b0, col_x};
                    state  <= RS_FETCH;
                end
                RS_FETCH: begin
                    // left half sits at the odd word
                    gfx_req  <= 1'b1;
                    gfx_addr <= {tile_num, ~half, row_idx[2:0] ^ {3{flip_y}}};
                    state    <= RS_GFX_WAIT;
                end
                RS_GFX_WAIT: begin
                    if (gfx_valid) begin
                        gfx_req  <= 1'b0;
                        pix_data <= gfx_data;
                        state    <= RS_DRAW;
                    end
                end
                RS_DRAW: begin
                    // pen 0 is transparent
                    lbuf_we    <= |pen;
                    lbuf_waddr <= {parity, xpos};
                    lbuf_wdata <= {4'b0000, colour, pen};
                    xpos       <= xpos + 9'd1;
                    ofs        <= ofs + 2'd1;
                    if (ofs == 2'd3) begin
                        if (!half) begin
                            half  <= 1'b1;
                            state <= RS_FETCH;
                        end else begin
                            state <= RS_NEXT;
                        end
                    end
                end
                RS_NEXT: begin
                    if (col != 5'(NUM_COLS - 1)) begin
                        col   <= col + 5'd1;
                        state <= RS_POS_RD;
                    end else if (layer != 2'(NUM_LAYERS - 1)) begin
                        layer <= layer + 2'd1;
                        state <= RS_LAYER;
                    end else begin
                        render_busy <= 1'b0;
                        state       <= RS_IDLE;
                    end
                end
                default: state <= RS_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/pixel_colour_pipeline.sv
// pixel colour pipeline, line buffer readout through CLUT and palette to 24-bit rgb
module pixel_colour_pipeline (
    input  logic                               clk_sys,
    input  logic                               reset,
    input  logic                               line_parity,
    input  logic                               lbuf_we,
    input  logic [nspace_pkg::LBUF_ADDR_W-1:0] lbuf_waddr,
    input  logic [15:0]                        lbuf_wdata,
    input  logic                               clut_we,
    input  logic [9:0]                         clut_waddr,
    input  logic [7:0]                         clut_wdata,
    input  logic                               pal_we,
    input  logic [7:0]                         pal_waddr,
    input  logic [31:0]                        pal_wdata,
    input  logic                               pix_req,
    input  logic [7:0]                         pix_x,
    output logic                               pix_valid,
    output logic [23:0]                        rgb
);
    import nspace_pkg::*;

    logic [15:0]            lbuf [2**LBUF_ADDR_W];
    logic [7:0]             clut [1024];
    logic [31:0]            pal [256];
    logic [LBUF_ADDR_W-1:0] lbuf_raddr;
    logic [15:0]            lbuf_rdata;
    logic [7:0]             clut_rdata;
    logic [31:0]            pal_rdata;
    logic [PIX_LATENCY-1:0] vld;

    // read the half the renderer is not writing
    assign lbuf_raddr = {~line_parity, 1'b0, pix_x};

    // ========================================
    // stage 1, line buffer
    always_ff @(posedge clk_sys) begin
        if (lbuf_we) begin
            lbuf[lbuf_waddr] <= lbuf_wdata;
        end
        lbuf_rdata <= lbuf[lbuf_raddr];
    end

    // stage 2, colour + pen into the clut
    always_ff @(posedge clk_sys) begin
        if (clut_we) begin
            clut[clut_waddr] <= clut_wdata;
        end
        clut_rdata <= clut[lbuf_rdata[9:0]];
    end

    // stage 3, palette
    always_ff @(posedge clk_sys) begin
        if (pal_we) begin
            pal[pal_waddr] <= pal_wdata;
        end
        pal_rdata <= pal[clut_rdata];
    end

    // stage 4, 4-bit guns widened by repetition
    always_ff @(posedge clk_sys) begin
        rgb <= {{2{pal_rdata[27:24]}}, {2{pal_rdata[19:16]}}, {2{pal_rdata[11:8]}}};
    end

    // ========================================
    // valid travels with the data
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            vld <= '0;
        end else begin
            vld <= {vld[PIX_LATENCY-2:0], pix_req};
        end
    end

    assign pix_valid = vld[PIX_LATENCY-1];

endmodule

//--- rtl/nspace_sprite_video.sv
// nspace sprite video top, table loader feeding the column renderer and colour readout
module nspace_sprite_video (
    input  logic                              clk_sys,
    input  logic                              reset,
    input  logic                              dl_active,
    input  logic                              dl_wr,
    input  logic [nspace_pkg::DL_ADDR_W-1:0]  dl_addr,
    input  logic [7:0]                        dl_data,
    input  logic                              spr_wr,
    input  logic [nspace_pkg::SPR_ADDR_W-1:0] spr_addr,
    input  nspace_pkg::spr_word_u             spr_data,
    input  logic                              line_start,
    input  logic [8:0]                        line_num,
    output logic                              render_busy,
    output logic                              gfx_req,
    output logic [nspace_pkg::GFX_ADDR_W-1:0] gfx_addr,
    input  logic                              gfx_valid,
    input  logic [15:0]                       gfx_data,
    input  logic                              pix_req,
    input  logic [7:0]                        pix_x,
    output logic                              pix_valid,
    output logic [23:0]                       rgb
);
    import nspace_pkg::*;

    // table writes
    logic        tcol_we;
    logic [14:0] tcol_waddr;
    logic [7:0]  tcol_wdata;
    logic        clut_we;
    logic [9:0]  clut_waddr;
    logic [7:0]  clut_wdata;
    logic        pal_we;
    logic [7:0]  pal_waddr;
    logic [31:0] pal_wdata;

    // renderer to line buffer
    logic                   lbuf_we;
    logic [LBUF_ADDR_W-1:0] lbuf_waddr;
    logic [15:0]            lbuf_wdata;

    table_loader u_loader (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .dl_active  (dl_active),
        .dl_wr      (dl_wr),
        .dl_addr    (dl_addr),
        .dl_data    (dl_data),
        .tcol_we    (tcol_we),
        .tcol_waddr (tcol_waddr),
        .tcol_wdata (tcol_wdata),
        .clut_we    (clut_we),
        .clut_waddr (clut_waddr),
        .clut_wdata (clut_wdata),
        .pal_we     (pal_we),
        .pal_waddr  (pal_waddr),
        .pal_wdata  (pal_wdata)
    );

    sprite_column_renderer u_renderer (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .line_start  (line_start),
        .line_num    (line_num),
        .spr_wr      (spr_wr),
        .spr_addr    (spr_addr),
        .spr_data    (spr_data),
        .tcol_we     (tcol_we),
        .tcol_waddr  (tcol_waddr),
        .tcol_wdata  (tcol_wdata),
        .gfx_valid   (gfx_valid),
        .gfx_data    (gfx_data),
        .gfx_req     (gfx_req),
        .gfx_addr    (gfx_addr),
        .lbuf_we     (lbuf_we),
        .lbuf_waddr  (lbuf_waddr),
        .lbuf_wdata  (lbuf_wdata),
        .render_busy (render_busy)
    );

    pixel_colour_pipeline u_pipeline (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .line_parity (line_num[0]),
        .lbuf_we     (lbuf_we),
        .lbuf_waddr  (lbuf_waddr),
        .lbuf_wdata  (lbuf_wdata),
        .clut_we     (clut_we),
        .clut_waddr  (clut_waddr),
        .clut_wdata  (clut_wdata),
        .pal_we      (pal_we),
        .pal_waddr   (pal_waddr),
        .pal_wdata   (pal_wdata),
        .pix_req     (pix_req),
        .pix_x       (pix_x),
        .pix_valid   (pix_valid),
        .rgb         (rgb)
    );

endmodule

//--- tb/sprite_video_checker.sv
// sprite video checker, protocol assertions bound to the top level
module sprite_video_checker (
    input logic                              clk_sys,
    input logic                              reset,
    input logic                              gfx_req,
    input logic [nspace_pkg::GFX_ADDR_W-1:0] gfx_addr,
    input logic                              gfx_valid,
    input logic                              pix_req,
    input logic                              pix_valid,
    input logic                              render_busy
);
    import nspace_pkg::*;

    // rom request held with a stable address until answered
    gfx_req_hold: assert property (@(posedge clk_sys) disable iff (reset)
        gfx_req && !gfx_valid |=> gfx_req && $stable(gfx_addr))
        else $error("gfx_req dropped or gfx_addr changed before gfx_valid");

    // fixed readout latency
    pix_latency: assert property (@(posedge clk_sys) disable iff (reset)
        pix_valid == $past(pix_req, PIX_LATENCY))
        else $error("pix_valid does not follow pix_req by the readout latency");

    // quiet right after reset
    reset_quiet: assert property (@(posedge clk_sys)
        $fell(reset) |-> !render_busy && !gfx_req)
        else $error("render_busy or gfx_req high in the first cycle after reset");

endmodule

bind nspace_sprite_video sprite_video_checker u_checker (.*);

//--- tb/tb_tests.svh
// sprite video directed tests and their driving helpers

// ========================================
// helpers

task automatic download_region(logic [DL_ADDR_W-1:0] base, int len);
    logic [7:0]  b;
    logic [3:0]  lo;
    logic [23:0] hold;
    for (int i = 0; i < len; i++) begin
        b = 8'(rand_bits(8));
        @(negedge clk_sys);
        dl_active = 1'b1;
        dl_wr     = 1'b1;
        dl_addr   = base + DL_ADDR_W'(i);
        dl_data   = b;
        if (base == TILE_COL_BASE) begin
            tcol_m[i] = b;
        end else if (base == CLUT_BASE) begin
            if (i % 2 == 0) lo = b[3:0];
            else clut_m[i / 2] = {b[3:0], lo};
        end else begin
            if (i % 4 == 3) pal_m[i / 4] = {hold, b};
            else hold = {hold[15:0], b};
        end
    end
    @(negedge clk_sys);
    dl_wr     = 1'b0;
    dl_active = 1'b0;
endtask

task automatic write_sprite(logic [11:0] a, logic [15:0] d);
    @(negedge clk_sys);
    spr_wr   = 1'b1;
    spr_addr = a;
    spr_data = d;
    spr_m[a] = d;
    @(negedge clk_sys);
    spr_wr = 1'b0;
endtask

// model of one line, three layers in the order 2, 3, 1
task automatic model_render(logic [8:0] n);
    logic [1:0]  grp;
    logic [15:0] pw;
    logic [15:0] tw;
    logic [15:0] gd;
    logic [7:0]  y;
    logic [7:0]  idx;
    logic [7:0]  colour;
    logic [3:0]  pen;
    logic [8:0]  pos;
    for (int i = 0; i < LINE_CLEAR_LEN; i++) lbuf_m[{n[0], 9'(i)}] = '0;
    for (int l = 0; l < 3; l++) begin
        grp = (l == 0) ? 2'd2 : (l == 1) ? 2'd3 : 2'd1;
        for (int c = 0; c < 32; c++) begin
            pw     = spr_m[{2'b00, 5'(c), 3'b000, grp}];
            y      = 8'd1 - pw[15:8];
            idx    = n[7:0] - y;
            tw     = spr_m[{grp, 5'(c), idx[7:3]}];
            colour = tcol_m[{tw[13:0], tw[15]}];
            for (int h = 0; h < 2; h++) begin
                gd = gfx_word({tw[13:0], ~1'(h), idx[2:0] ^ {3{tw[14]}}});
                for (int o = 0; o < 4; o++) begin
                    pen = {gd[4+o], gd[o], gd[12+o], gd[8+o]};
                    pos = {1'b0, pw[7:0]} + 9'(h * 4 + o);
                    if (pen != 4'd0) lbuf_m[{n[0], pos}] = {4'b0000, colour, pen};
                end
            end
        end
    end
endtask

task automatic render_line(logic [8:0] n);
    int cnt;
    @(negedge clk_sys);
    line_num   = n;
    line_start = 1'b1;
    @(negedge clk_sys);
    line_start = 1'b0;
    if (render_busy !== 1'b1) begin
        value_errs++;
        $display("FAIL %0t render_busy expected 1 got %b", $time, render_busy);
    end
    cnt = 0;
    while (render_busy && cnt < LINE_TIMEOUT) begin
        @(negedge clk_sys);
        cnt++;
    end
    if (render_busy) begin
        other_errs++;
        $display("render of line %0d never finished", n);
    end
    model_render(n);
endtask

// flip the readout to line n's half without rendering
task automatic show_line(logic [8:0] n);
    @(negedge clk_sys);
    line_num = n + 9'd1;
endtask

task automatic read_pixels();
    int cnt;
    for (int x = 0; x < 256; x++) begin
        @(negedge clk_sys);
        pix_req = 1'b1;
        pix_x   = 8'(x);
        exp_q.push_back(exp_rgb(line_num[0], 8'(x)));
        req_q.push_back(cyc);
    end
    @(negedge clk_sys);
    pix_req = 1'b0;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < 20) begin
        @(negedge clk_sys);
        cnt++;
    end
    if (exp_q.size() != 0) begin
        other_errs++;
        $display("readout stopped with %0d pixels missing", exp_q.size());
        exp_q.delete();
        req_q.delete();
    end
endtask

// ========================================
// tests

task automatic test_table_load();
    download_region(TILE_COL_BASE, int'(TILE_COL_LEN));
    download_region(CLUT_BASE, int'(CLUT_LEN));
    download_region(PAL_BASE, int'(PAL_LEN));
    for (int a = 0; a < 4096; a++) write_sprite(12'(a), 16'h0000);
    render_line(9'd0);
    show_line(9'd0);
    read_pixels();
endtask

task automatic test_single_column();
    // group 2 column 5, stored y 0 so line 20 reads row 19
    write_sprite({2'b00, 5'd5, 3'b000, 2'd2}, 16'h0028);
    write_sprite({2'd2, 5'd5, 5'd2}, 16'h8123);
    render_line(9'd20);
    show_line(9'd20);
    read_pixels();
endtask

task automatic test_vertical_flip();
    write_sprite({2'd2, 5'd5, 5'd2}, 16'hc123);
    render_line(9'd20);
    show_line(9'd20);
    read_pixels();
endtask

task automatic test_layer_order();
    write_sprite({2'b00, 5'd7, 3'b000, 2'd3}, 16'h002c);
    write_sprite({2'd3, 5'd7, 5'd2}, 16'h0456);
    write_sprite({2'b00, 5'd2, 3'b000, 2'd1}, 16'h002a);
    write_sprite({2'd1, 5'd2, 5'd2}, 16'h8789);
    render_line(9'd20);
    show_line(9'd20);
    read_pixels();
endtask

task automatic test_latency_double_buffer();
    render_line(9'd21);
    // readout turns to line 21's half before line 22 starts
    show_line(9'd21);
    // read line 21 while line 22 renders into the other half
    fork
        render_line(9'd22);
        read_pixels();
    join
    show_line(9'd22);
    read_pixels();
endtask

//--- tb/tb_top.sv
// testbench top for the sprite video block, with rom model, reference model and checks
module tb_top;
    import nspace_pkg::*;

    localparam int LINE_TIMEOUT    = 6000;
    localparam int NUM_RENDERS     = 6;
    localparam int WATCHDOG_CYCLES = 36000 + 2 * 4200 + NUM_RENDERS * LINE_TIMEOUT + 3000;

    logic                  clk_sys;
    logic                  reset;
    logic                  dl_active;
    logic                  dl_wr;
    logic [DL_ADDR_W-1:0]  dl_addr;
    logic [7:0]            dl_data;
    logic                  spr_wr;
    logic [SPR_ADDR_W-1:0] spr_addr;
    logic [15:0]           spr_data;
    logic                  line_start;
    logic [8:0]            line_num;
    logic                  render_busy;
    logic                  gfx_req;
    logic [GFX_ADDR_W-1:0] gfx_addr;
    logic                  gfx_valid;
    logic [15:0]           gfx_data;
    logic                  pix_req;
    logic [7:0]            pix_x;
    logic                  pix_valid;
    logic [23:0]           rgb;

    // reference copies of the tables and buffers
    logic [7:0]  tcol_m [32768];
    logic [7:0]  clut_m [1024];
    logic [31:0] pal_m [256];
    logic [15:0] spr_m [4096];
    logic [15:0] lbuf_m [1024];

    logic [31:0] lfsr;
    int          cyc;
    int          value_errs;
    int          other_errs;
    logic [23:0] exp_q[$];
    int          req_q[$];

    nspace_sprite_video u_dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) cyc <= cyc + 1;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // bitmap content, tile 0 is blank and odd words lose pen column 1
    function automatic logic [15:0] gfx_word(logic [17:0] a);
        logic [15:0] h;
        if (a[17:4] == 14'd0) begin
            return 16'h0000;
        end
        h = 16'(a * 32'd953) ^ 16'h1c5 ^ {a[7:0], a[17:10]};
        return h & (a[0] ? 16'hdddd : 16'hffff);
    endfunction

    function automatic logic [23:0] exp_rgb(logic par, logic [7:0] x);
        logic [15:0] e;
        logic [31:0] p;
        e = lbuf_m[{~par, 1'b0, x}];
        p = pal_m[clut_m[e[9:0]]];
        return {{2{p[27:24]}}, {2{p[19:16]}}, {2{p[11:8]}}};
    endfunction

    // ========================================
    // graphics rom, 1 to 8 cycles of latency
    initial begin
        int d;
        forever begin
            @(negedge clk_sys);
            if (gfx_req && !reset) begin
                d = 1 + int'(rand_bits(3));
                repeat (d - 1) @(negedge clk_sys);
                gfx_valid = 1'b1;
                gfx_data  = gfx_word(gfx_addr);
                @(negedge clk_sys);
                gfx_valid = 1'b0;
            end
        end
    end

    // readout monitor
    always @(negedge clk_sys) begin : readout_monitor
        logic [23:0] e;
        int          c;
        if (!reset && pix_valid) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("pix_valid arrived with no request outstanding at %0t", $time);
            end else begin
                e = exp_q.pop_front();
                c = req_q.pop_front();
                if (cyc - c != PIX_LATENCY) begin
                    value_errs++;
                    $display("FAIL %0t pix_valid latency expected %0d got %0d", $time,
                             PIX_LATENCY, cyc - c);
                end
                if (rgb !== e) begin
                    value_errs++;
                    $display("FAIL %0t rgb expected %h got %h", $time, e, rgb);
                end
            end
        end
    end

    // ========================================
    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        $display("watchdog expired, the run took too long");
        $display("** FAIL **");
        $finish;
    end

    `include "tb_tests.svh"

    initial begin
        lfsr = 32'h336;
        value_errs = 0;
        other_errs = 0;
        reset = 1'b1;
        dl_active = 1'b0;
        dl_wr = 1'b0;
        dl_addr = '0;
        dl_data = '0;
        spr_wr = 1'b0;
        spr_addr = '0;
        spr_data = '0;
        line_start = 1'b0;
        line_num = '0;
        gfx_valid = 1'b0;
        gfx_data = '0;
        pix_req = 1'b0;
        pix_x = '0;
        repeat (10) @(posedge clk_sys);
        @(negedge clk_sys);
        reset = 1'b0;
        test_table_load();
        test_single_column();
        test_vertical_flip();
        test_layer_order();
        test_latency_double_buffer();
        repeat (4) @(negedge clk_sys);
        $display("value errors %0d, other errors %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+tb
rtl/nspace_pkg.sv
rtl/table_loader.sv
rtl/sprite_column_renderer.sv
rtl/pixel_colour_pipeline.sv
rtl/nspace_sprite_video.sv
tb/sprite_video_checker.sv
tb/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the sprite video testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f compile.f --top-module tb_top \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/Vtb_top)"
echo "$out"
grep -qF '** PASS **' <<< "$out" && exit 0 || exit 1
